/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// Datapath and register file
	localparam int xlen = 32;
	localparam int nregs = 16;

	// Memory depths in words
	localparam int imem_words = 64;
	localparam int dmem_words = 64;

	// Word index into the instruction memory
	localparam int pc_bits = 6;

	// Operations handed from decode to execute
	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_addi,
		op_lui,
		op_lw,
		op_sw,
		op_beq,
		op_bne,
		op_jal,
		op_halt
	} opcode_e;

	// Decode issue FSM
	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_halted
	} issue_state_e;

	// Fetch FSM
	typedef enum logic {
		fs_run,
		fs_stop
	} fetch_state_e;

endpackage

`default_nettype wire

/* verilog/cpu_ifu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_ifu (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          imem_we,
	input  logic [cpu_pkg::pc_bits-1:0]   imem_addr,
	input  logic [cpu_pkg::xlen-1:0]      imem_wdata,
	output logic                          f_valid,
	input  logic                          f_ready,
	output logic [cpu_pkg::xlen-1:0]      f_pc,
	output logic [cpu_pkg::xlen-1:0]      f_instr,
	input  logic                          redirect,
	input  logic [cpu_pkg::xlen-1:0]      redirect_pc,
	input  logic                          halt
);
	import cpu_pkg::*;

	logic [xlen-1:0] imem [imem_words];
	logic [xlen-1:0] pc;
	fetch_state_e    state;
	logic            launch;

	// New read when the output slot is free or drains this cycle
	assign launch = !reset && state == fs_run && !redirect && !halt && (!f_valid || f_ready);

	// Program load during reset, synchronous read otherwise
	always_ff @(posedge clk) begin
		if (reset && imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
		if (launch) begin
			f_instr <= imem[pc[pc_bits+1:2]];
			f_pc <= pc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			f_valid <= 1'b0;
			state <= fs_run;
		end else if (redirect) begin
			// Stale word is dropped, restart at target
			pc <= redirect_pc;
			f_valid <= 1'b0;
		end else if (halt) begin
			state <= fs_stop;
			f_valid <= 1'b0;
		end else if (launch) begin
			pc <= pc + 32'd4;
			f_valid <= 1'b1;
		end else if (f_valid && f_ready) begin
			f_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/cpu_fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch_queue (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     flush,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic [cpu_pkg::xlen-1:0] in_pc,
	input  logic [cpu_pkg::xlen-1:0] in_instr,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic [cpu_pkg::xlen-1:0] out_pc,
	output logic [cpu_pkg::xlen-1:0] out_instr
);
	import cpu_pkg::*;

	logic [xlen-1:0] pc_mem [2];
	logic [xlen-1:0] instr_mem [2];
	logic            wr_ptr;
	logic            rd_ptr;
	logic [1:0]      count;
	logic [1:0]      count_next;
	logic            push;
	logic            pop;

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	assign out_valid = count != 2'd0;
	assign out_pc = pc_mem[rd_ptr];
	assign out_instr = instr_mem[rd_ptr];

	always_comb begin
		if (flush) begin
			count_next = 2'd0;
		end else begin
			count_next = count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			pc_mem[wr_ptr] <= in_pc;
			instr_mem[wr_ptr] <= in_instr;
		end
	end

	// Ready is registered so it stays low through reset
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
			in_ready <= 1'b0;
		end else begin
			if (flush) begin
				wr_ptr <= 1'b0;
				rd_ptr <= 1'b0;
			end else begin
				if (push)
					wr_ptr <= ~wr_ptr;
				if (pop)
					rd_ptr <= ~rd_ptr;
			end
			count <= count_next;
			in_ready <= count_next != 2'd2;
		end
	end

endmodule

`default_nettype wire

/* verilog/cpu_idu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_idu (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     q_valid,
	output logic                     q_ready,
	input  logic [cpu_pkg::xlen-1:0] q_pc,
	input  logic [cpu_pkg::xlen-1:0] q_instr,
	output logic                     i_valid,
	output cpu_pkg::opcode_e         i_op,
	output logic [cpu_pkg::xlen-1:0] i_pc,
	output logic [cpu_pkg::xlen-1:0] i_rs1_data,
	output logic [cpu_pkg::xlen-1:0] i_rs2_data,
	output logic [cpu_pkg::xlen-1:0] i_imm,
	output logic [3:0]               i_rd,
	input  logic                     wb_valid,
	input  logic [3:0]               wb_rd,
	input  logic [cpu_pkg::xlen-1:0] wb_data,
	input  logic                     retire,
	output logic                     halt,
	input  logic [3:0]               dbg_addr,
	output logic [cpu_pkg::xlen-1:0] dbg_data
);
	import cpu_pkg::*;

	logic [xlen-1:0] regs [nregs];
	issue_state_e    state;
	opcode_e         dec_op;
	logic [xlen-1:0] dec_imm;
	logic [6:0]      opc;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [3:0]      rs1;
	logic [3:0]      rs2;
	logic            pop;

	assign opc = q_instr[6:0];
	assign funct3 = q_instr[14:12];
	assign funct7 = q_instr[31:25];
	// RV32E, upper register bit ignored
	assign rs1 = q_instr[18:15];
	assign rs2 = q_instr[23:20];

	assign q_ready = state == st_idle;
	assign pop = q_valid && q_ready;
	assign halt = state == st_halted;

	always_comb begin
		dec_op = op_halt;
		dec_imm = {{20{q_instr[31]}}, q_instr[31:20]};
		case (opc)
			7'b0110011: begin
				if (funct3 == 3'b000 && funct7 == 7'b0000000)
					dec_op = op_add;
				else if (funct3 == 3'b000 && funct7 == 7'b0100000)
					dec_op = op_sub;
			end
			7'b0010011: if (funct3 == 3'b000) dec_op = op_addi;
			7'b0110111: begin
				dec_op = op_lui;
				dec_imm = {q_instr[31:12], 12'b0};
			end
			7'b0000011: if (funct3 == 3'b010) dec_op = op_lw;
			7'b0100011: begin
				if (funct3 == 3'b010)
					dec_op = op_sw;
				dec_imm = {{20{q_instr[31]}}, q_instr[31:25], q_instr[11:7]};
			end
			7'b1100011: begin
				if (funct3 == 3'b000)
					dec_op = op_beq;
				else if (funct3 == 3'b001)
					dec_op = op_bne;
				dec_imm = {{19{q_instr[31]}}, q_instr[31], q_instr[7],
					q_instr[30:25], q_instr[11:8], 1'b0};
			end
			7'b1101111: begin
				dec_op = op_jal;
				dec_imm = {{11{q_instr[31]}}, q_instr[31], q_instr[19:12],
					q_instr[20], q_instr[30:21], 1'b0};
			end
			default: dec_op = op_halt;
		endcase
	end

	// Register file, x0 never written
	always_ff @(posedge clk) begin
		if (wb_valid && wb_rd != 4'd0)
			regs[wb_rd] <= wb_data;
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			i_op <= dec_op;
			i_pc <= q_pc;
			i_rs1_data <= (rs1 == 4'd0) ? '0 : regs[rs1];
			i_rs2_data <= (rs2 == 4'd0) ? '0 : regs[rs2];
			i_imm <= dec_imm;
			i_rd <= q_instr[10:7];
		end
	end

	// One instruction in flight at a time
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			i_valid <= 1'b0;
		end else begin
			i_valid <= pop && dec_op != op_halt;
			case (state)
				st_idle: if (pop) state <= (dec_op == op_halt) ? st_halted : st_wait;
				st_wait: if (retire) state <= st_idle;
				default: state <= st_halted;
			endcase
		end
	end

	assign dbg_data = (dbg_addr == 4'd0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

/* verilog/cpu_exeu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_exeu (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     i_valid,
	input  cpu_pkg::opcode_e         i_op,
	input  logic [cpu_pkg::xlen-1:0] i_pc,
	input  logic [cpu_pkg::xlen-1:0] i_rs1_data,
	input  logic [cpu_pkg::xlen-1:0] i_rs2_data,
	input  logic [cpu_pkg::xlen-1:0] i_imm,
	input  logic [3:0]               i_rd,
	output logic                     wb_valid,
	output logic [3:0]               wb_rd,
	output logic [cpu_pkg::xlen-1:0] wb_data,
	output logic                     retire,
	output logic                     redirect,
	output logic [cpu_pkg::xlen-1:0] redirect_pc
);
	import cpu_pkg::*;

	logic [xlen-1:0]                 dmem [dmem_words];
	logic [xlen-1:0]                 mem_addr;
	logic [$clog2(dmem_words)-1:0]   dmem_idx;
	logic [xlen-1:0]                 load_data;
	logic                            store_en;
	logic                            rs_equal;
	logic                            taken;
	logic                            writes_rd;

	// Word addressed, byte offset ignored
	assign mem_addr = i_rs1_data + i_imm;
	assign dmem_idx = mem_addr[$clog2(dmem_words)+1:2];
	assign load_data = dmem[dmem_idx];

	assign store_en = !reset && i_valid && i_op == op_sw;

	always_ff @(posedge clk) begin
		if (store_en)
			dmem[dmem_idx] <= i_rs2_data;
	end

	assign rs_equal = i_rs1_data == i_rs2_data;

	always_comb begin
		taken = 1'b0;
		case (i_op)
			op_beq: taken = rs_equal;
			op_bne: taken = !rs_equal;
			op_jal: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		writes_rd = 1'b1;
		wb_data = '0;
		case (i_op)
			op_add:  wb_data = i_rs1_data + i_rs2_data;
			op_sub:  wb_data = i_rs1_data - i_rs2_data;
			op_addi: wb_data = i_rs1_data + i_imm;
			op_lui:  wb_data = i_imm;
			op_lw:   wb_data = load_data;
			// Link value
			op_jal:  wb_data = i_pc + 32'd4;
			default: writes_rd = 1'b0;
		endcase
	end

	// Whole instruction finishes in the issue cycle
	assign retire = i_valid;
	assign wb_valid = i_valid && writes_rd;
	assign wb_rd = i_rd;

	assign redirect = i_valid && taken;
	assign redirect_pc = i_pc + i_imm;

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        imem_we,
	input  logic [cpu_pkg::pc_bits-1:0] imem_addr,
	input  logic [cpu_pkg::xlen-1:0]    imem_wdata,
	output logic                        halted,
	input  logic [3:0]                  dbg_addr,
	output logic [cpu_pkg::xlen-1:0]    dbg_data
);
	import cpu_pkg::*;

	// Fetch to queue
	logic            f_valid;
	logic            f_ready;
	logic [xlen-1:0] f_pc;
	logic [xlen-1:0] f_instr;

	// Queue to decode
	logic            q_valid;
	logic            q_ready;
	logic [xlen-1:0] q_pc;
	logic [xlen-1:0] q_instr;

	// Decode to execute
	logic            i_valid;
	opcode_e         i_op;
	logic [xlen-1:0] i_pc;
	logic [xlen-1:0] i_rs1_data;
	logic [xlen-1:0] i_rs2_data;
	logic [xlen-1:0] i_imm;
	logic [3:0]      i_rd;

	// Execute back to decode and fetch
	logic            wb_valid;
	logic [3:0]      wb_rd;
	logic [xlen-1:0] wb_data;
	logic            retire;
	logic            redirect;
	logic [xlen-1:0] redirect_pc;

	cpu_ifu ifu_i (
		.clk(clk), .reset(reset),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.f_valid(f_valid), .f_ready(f_ready), .f_pc(f_pc), .f_instr(f_instr),
		.redirect(redirect), .redirect_pc(redirect_pc), .halt(halted)
	);

	cpu_fetch_queue fetch_queue_i (
		.clk(clk), .reset(reset), .flush(redirect),
		.in_valid(f_valid), .in_ready(f_ready), .in_pc(f_pc), .in_instr(f_instr),
		.out_valid(q_valid), .out_ready(q_ready), .out_pc(q_pc), .out_instr(q_instr)
	);

	cpu_idu idu_i (
		.clk(clk), .reset(reset),
		.q_valid(q_valid), .q_ready(q_ready), .q_pc(q_pc), .q_instr(q_instr),
		.i_valid(i_valid), .i_op(i_op), .i_pc(i_pc),
		.i_rs1_data(i_rs1_data), .i_rs2_data(i_rs2_data), .i_imm(i_imm), .i_rd(i_rd),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .retire(retire),
		.halt(halted), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
	);

	cpu_exeu exeu_i (
		.clk(clk), .reset(reset),
		.i_valid(i_valid), .i_op(i_op), .i_pc(i_pc),
		.i_rs1_data(i_rs1_data), .i_rs2_data(i_rs2_data), .i_imm(i_imm), .i_rd(i_rd),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .retire(retire),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

endmodule

`default_nettype wire

/* tests/cpu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions (
	input logic       clk,
	input logic       reset,
	input logic       flush,
	input logic       in_valid,
	input logic       in_ready,
	input logic       out_valid,
	input logic [1:0] count
);

	// Occupancy cannot grow without an accepted push
	assert property (@(posedge clk) disable iff (reset)
		(in_valid && !in_ready && !flush) |=> count <= $past(count))
	else $error("fetch queue accepted a push while in_ready was low");

	assert property (@(posedge clk) disable iff (reset) flush |=> !out_valid)
	else $error("fetch queue output valid in the cycle after a flush");

	assert property (@(posedge clk) reset |=> (!out_valid && !in_ready))
	else $error("fetch queue not idle in the cycle after reset");

endmodule

bind cpu_fetch_queue cpu_assertions queue_checks_i (
	.clk(clk),
	.reset(reset),
	.flush(flush),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.out_valid(out_valid),
	.count(count)
);

`default_nettype wire

/* tests/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	logic               clk;
	logic               reset;
	logic               imem_we;
	logic [pc_bits-1:0] imem_addr;
	logic [xlen-1:0]    imem_wdata;
	logic               halted;
	logic [3:0]         dbg_addr;
	logic [xlen-1:0]    dbg_data;

	// Current test as read from the case file
	string              test_name;
	logic [pc_bits-1:0] prog_addr [$];
	logic [xlen-1:0]    prog_word [$];
	logic [3:0]         exp_reg [$];
	logic [xlen-1:0]    exp_val [$];
	int                 n_pass;
	int                 n_fail;

	cpu_top cpu_top_i (
		.clk(clk),
		.reset(reset),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.halted(halted),
		.dbg_addr(dbg_addr),
		.dbg_data(dbg_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic run_test();
		int i;
		int cycles;
		int errors;
		reset = 1'b1;
		// Reset covers at least 4 cycles and the whole program load
		for (i = 0; i < 4 || i < prog_word.size(); i++) begin
			imem_we = i < prog_word.size();
			if (i < prog_word.size()) begin
				imem_addr = prog_addr[i];
				imem_wdata = prog_word[i];
			end
			step();
		end
		imem_we = 1'b0;
		reset = 1'b0;
		cycles = 0;
		errors = 0;
		while (!halted && cycles < 2000) begin
			step();
			cycles++;
		end
		if (!halted) begin
			$display("Test %s: the program did not halt within 2000 cycles", test_name);
			errors++;
		end else begin
			for (i = 0; i < exp_reg.size(); i++) begin
				dbg_addr = exp_reg[i];
				step();
				assert (dbg_data === exp_val[i]) else begin
					$display("ERROR %s: x%0d expected %08h, actual %08h",
						test_name, exp_reg[i], exp_val[i], dbg_data);
					errors++;
				end
			end
		end
		if (errors == 0) begin
			$display("PASS %s", test_name);
			n_pass++;
		end else begin
			$display("FAIL %s (%0d errors)", test_name, errors);
			n_fail++;
		end
	endtask

	initial begin
		int          fd;
		string       line;
		string       kw;
		logic [31:0] a;
		logic [31:0] w;
		bit          have_test;
		reset = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		dbg_addr = '0;
		n_pass = 0;
		n_fail = 0;
		have_test = 1'b0;
		step();
		fd = $fopen("tests/cpu_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file tests/cpu_cases.txt");
			n_fail++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				kw = "";
				void'($fgets(line, fd));
				void'($sscanf(line, "%s", kw));
				if (kw == "test") begin
					if (have_test)
						run_test();
					void'($sscanf(line, "%s %s", kw, test_name));
					prog_addr.delete();
					prog_word.delete();
					exp_reg.delete();
					exp_val.delete();
					have_test = 1'b1;
				end else if (kw == "inst") begin
					void'($sscanf(line, "%s %h %h", kw, a, w));
					prog_addr.push_back(a[pc_bits-1:0]);
					prog_word.push_back(w);
				end else if (kw == "expect") begin
					void'($sscanf(line, "%s %d %h", kw, a, w));
					exp_reg.push_back(a[3:0]);
					exp_val.push_back(w);
				end
			end
			$fclose(fd);
			if (have_test)
				run_test();
		end
		$display("Tests: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0 && n_pass > 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/cpu_cases.txt */
# test <name> | inst <word index, hex> <instruction, hex>
# expect <register, decimal> <value, hex>

test alu_lui
inst 00 00500093
inst 01 FFD00113
inst 02 002081B3
inst 03 40208233
inst 04 800002B7
inst 05 FFF28313
inst 06 005283B3
inst 07 DEADC537
inst 08 EEF50513
inst 09 00700013
inst 0A 00100073
expect 2 FFFFFFFD
expect 3 00000002
expect 4 00000008
expect 6 7FFFFFFF
expect 7 00000000
expect 10 DEADBEEF
expect 0 00000000

test load_store
inst 00 01100093
inst 01 ABCDE137
inst 02 04000193
inst 03 00102023
inst 04 00202223
inst 05 0031A423
inst 06 0011A223
inst 07 00002203
inst 08 00402283
inst 09 0081A303
inst 0A 0041A383
inst 0B 00100073
expect 4 00000011
expect 5 ABCDE000
expect 6 00000040
expect 7 00000011

test branches
inst 00 FFF00293
inst 01 00100093
inst 02 00100113
inst 03 00208663
inst 04 05500293
inst 05 06600293
inst 06 00209463
inst 07 00300193
inst 08 00009463
inst 09 07700293
inst 0A 00008463
inst 0B 00400213
inst 0C 00100073
expect 3 00000003
expect 4 00000004
expect 5 FFFFFFFF

test jal_loop
inst 00 00000093
inst 01 00A00113
inst 02 00108093
inst 03 FE209EE3
inst 04 008001EF
inst 05 00100073
inst 06 00600313
inst 07 00100073
expect 1 0000000A
expect 3 00000014
expect 6 00000006

/* tb.f */
verilog/cpu_pkg.sv
verilog/cpu_ifu.sv
verilog/cpu_fetch_queue.sv
verilog/cpu_idu.sv
verilog/cpu_exeu.sv
verilog/cpu_top.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module cpu_tb -f tb.f -o cpu_sim &&
./obj_dir/cpu_sim | tee /dev/stderr | grep -q "All tests passed!" || exit 1
